/* hw/decode_stage.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module decode_stage
  import lc3b_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  lc3b_word inst,
  input  logic     inst_valid,
  input  logic     mem_stall,
  input  wb_fwd_t  wb,
  output id_ex_t   id_ex,
  output logic     id_ex_valid,
  output logic     load_use
);

  lc3b_word   regs [`LC3B_REG_COUNT];
  lc3b_opcode opcode;
  ctrl_word_t ctrl;
  lc3b_reg    sr1;
  lc3b_reg    sr2;
  lc3b_reg    dest;
  lc3b_word   sr1_val;
  lc3b_word   sr2_val;
  lc3b_word   imm;
  logic       uses_sr1;
  logic       uses_sr2;
  id_ex_t     id_ex_next;

  assign opcode = lc3b_opcode'(inst[15:12]);
  assign dest   = inst[11:9];
  assign sr1    = inst[8:6];
  assign sr2    = (opcode == op_str) ? inst[11:9] : inst[2:0];  // str source sits in dr slot

  // control rom
  always_comb begin
    ctrl.opcode       = opcode;
    ctrl.aluop        = alu_pass;
    ctrl.use_imm      = 1'b0;
    ctrl.use_offset   = 1'b0;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.load_regfile = 1'b0;
    case (opcode)
      op_add: begin
        ctrl.aluop        = alu_add;
        ctrl.use_imm      = inst[5];
        ctrl.load_regfile = 1'b1;
      end
      op_and: begin
        ctrl.aluop        = alu_and;
        ctrl.use_imm      = inst[5];
        ctrl.load_regfile = 1'b1;
      end
      op_not: begin
        ctrl.aluop        = alu_not;
        ctrl.load_regfile = 1'b1;
      end
      op_ldr: begin
        ctrl.aluop        = alu_add;
        ctrl.use_offset   = 1'b1;
        ctrl.mem_read     = 1'b1;
        ctrl.load_regfile = 1'b1;
      end
      op_str: begin
        ctrl.aluop      = alu_add;
        ctrl.use_offset = 1'b1;
        ctrl.mem_write  = 1'b1;
      end
      default: ;               // nop
    endcase
  end

  assign imm = ctrl.use_offset ? {{(`LC3B_WORD_W-7){inst[5]}}, inst[5:0], 1'b0}
                               : {{(`LC3B_WORD_W-5){inst[4]}}, inst[4:0]};

  // register file with write-through on the read side
  assign sr1_val = (wb.valid && wb.dest == sr1) ? wb.value : regs[sr1];
  assign sr2_val = (wb.valid && wb.dest == sr2) ? wb.value : regs[sr2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `LC3B_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.dest] <= wb.value;
    end
  end

  // load in id/ex feeding a source of the word in if/id
  assign uses_sr1 = ctrl.load_regfile | ctrl.mem_write;
  assign uses_sr2 = (opcode == op_str) |
                    ((opcode == op_add || opcode == op_and) && !ctrl.use_imm);
  assign load_use = inst_valid & id_ex_valid & id_ex.ctrl.mem_read &
                    ((uses_sr1 && id_ex.dest == sr1) || (uses_sr2 && id_ex.dest == sr2));

  always_comb begin
    id_ex_next.ctrl    = ctrl;
    id_ex_next.sr1     = sr1;
    id_ex_next.sr2     = sr2;
    id_ex_next.dest    = dest;
    id_ex_next.sr1_val = sr1_val;
    id_ex_next.sr2_val = sr2_val;
    id_ex_next.imm     = imm;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex_valid <= 1'b0;
    end else if (!mem_stall) begin
      id_ex_valid <= inst_valid & ~load_use;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      id_ex <= id_ex_next;
    end else begin
      // held entry must not miss a result retiring during the stall
      if (wb.valid && wb.dest == id_ex.sr1) id_ex.sr1_val <= wb.value;
      if (wb.valid && wb.dest == id_ex.sr2) id_ex.sr2_val <= wb.value;
    end
  end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
  import lc3b_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  id_ex_t  id_ex,
  input  logic    id_ex_valid,
  input  logic    mem_stall,
  input  wb_fwd_t wb,
  output ex_mem_t ex_mem,
  output logic    ex_mem_valid
);

  logic     mem_fwd_ok;
  lc3b_word src_a;
  lc3b_word src_b;
  lc3b_word operand_b;
  lc3b_word alu_out;

  // a load in ex/mem has no data yet
  assign mem_fwd_ok = ex_mem_valid & ex_mem.ctrl.load_regfile & ~ex_mem.ctrl.mem_read;

  assign src_a = (mem_fwd_ok && ex_mem.dest == id_ex.sr1) ? ex_mem.alu_out :
                 (wb.valid && wb.dest == id_ex.sr1)       ? wb.value      : id_ex.sr1_val;
  assign src_b = (mem_fwd_ok && ex_mem.dest == id_ex.sr2) ? ex_mem.alu_out :
                 (wb.valid && wb.dest == id_ex.sr2)       ? wb.value      : id_ex.sr2_val;

  assign operand_b = (id_ex.ctrl.use_imm | id_ex.ctrl.use_offset) ? id_ex.imm : src_b;

  always_comb begin
    unique case (id_ex.ctrl.aluop)
      alu_add:  alu_out = src_a + operand_b;   // also base + offset for ldr/str
      alu_and:  alu_out = src_a & operand_b;
      alu_not:  alu_out = ~src_a;
      alu_pass: alu_out = operand_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem_valid <= 1'b0;
    end else if (!mem_stall) begin
      ex_mem_valid <= id_ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.alu_out    <= alu_out;
      ex_mem.store_data <= src_b;  // forwarded str source
    end
  end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module fetch_unit
  import lc3b_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load_use,
  input  logic     mem_stall,
  output logic     icache_read,
  output lc3b_word icache_address,
  input  logic     icache_resp,
  input  lc3b_word icache_rdata,
  output lc3b_word inst,
  output logic     inst_valid
);

  lc3b_word pc;
  logic     hold;
  logic     accept;

  assign hold           = load_use | mem_stall;
  assign accept         = icache_read & icache_resp & ~hold;
  assign icache_address = pc;

  // request goes up one cycle out of reset and stays up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      icache_read <= 1'b0;
      pc          <= `LC3B_RESET_PC;
    end else begin
      icache_read <= 1'b1;
      if (accept) begin
        pc <= pc + lc3b_word'(2);
      end
    end
  end

  // if/id, bubble when no response this cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_valid <= 1'b0;
    end else if (!hold) begin
      inst_valid <= icache_read & icache_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst <= icache_rdata;   // a dropped word is simply refetched
    end
  end

endmodule

/* hw/lc3b_core.sv */
`timescale 1ns/1ns

module lc3b_core
  import lc3b_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output logic      icache_read,
  output lc3b_word  icache_address,
  input  logic      icache_resp,
  input  lc3b_word  icache_rdata,
  output dmem_req_t dcache_req,
  input  logic      dcache_resp,
  input  lc3b_word  dcache_rdata
);

  lc3b_word inst;
  logic     inst_valid;
  logic     load_use;
  logic     mem_stall;
  id_ex_t   id_ex;
  logic     id_ex_valid;
  ex_mem_t  ex_mem;
  logic     ex_mem_valid;
  wb_fwd_t  wb;              // writeback port, also the late forward source

  fetch_unit fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_use       (load_use),
    .mem_stall      (mem_stall),
    .icache_read    (icache_read),
    .icache_address (icache_address),
    .icache_resp    (icache_resp),
    .icache_rdata   (icache_rdata),
    .inst           (inst),
    .inst_valid     (inst_valid)
  );

  decode_stage decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .mem_stall   (mem_stall),
    .wb          (wb),
    .id_ex       (id_ex),
    .id_ex_valid (id_ex_valid),
    .load_use    (load_use)
  );

  execute_stage execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex        (id_ex),
    .id_ex_valid  (id_ex_valid),
    .mem_stall    (mem_stall),
    .wb           (wb),
    .ex_mem       (ex_mem),
    .ex_mem_valid (ex_mem_valid)
  );

  result_stage result (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_mem       (ex_mem),
    .ex_mem_valid (ex_mem_valid),
    .dcache_req   (dcache_req),
    .dcache_resp  (dcache_resp),
    .dcache_rdata (dcache_rdata),
    .mem_stall    (mem_stall),
    .wb           (wb)
  );

endmodule

/* hw/lc3b_pkg.sv */
`include "lc3b_settings.svh"

package lc3b_pkg;

  typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
  typedef logic [$clog2(`LC3B_REG_COUNT)-1:0] lc3b_reg;

  // lc-3b encodings, anything else runs as a nop
  typedef enum logic [3:0] {
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_not = 4'b1001,
    op_ldr = 4'b0110,
    op_str = 4'b0111
  } lc3b_opcode;

  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
  } alu_op_e;

  typedef struct packed {
    lc3b_opcode opcode;
    alu_op_e    aluop;
    logic       use_imm;      // imm5 instead of sr2
    logic       use_offset;   // offset6 as address offset
    logic       mem_read;
    logic       mem_write;
    logic       load_regfile;
  } ctrl_word_t;

  typedef struct packed {
    ctrl_word_t ctrl;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    lc3b_reg    dest;
    lc3b_word   sr1_val;
    lc3b_word   sr2_val;
    lc3b_word   imm;          // sext imm5 or offset6 << 1
  } id_ex_t;

  typedef struct packed {
    ctrl_word_t ctrl;
    lc3b_reg    dest;
    lc3b_word   alu_out;      // result or address
    lc3b_word   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     load_regfile;
    lc3b_reg  dest;
    lc3b_word value;
  } mem_wb_t;

  typedef struct packed {
    logic     valid;
    lc3b_reg  dest;
    lc3b_word value;
  } wb_fwd_t;

  typedef struct packed {
    logic     read;
    logic     write;
    lc3b_word address;
    lc3b_word wdata;
  } dmem_req_t;

endpackage

/* hw/lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// datapath and address width
`define LC3B_WORD_W    16

// architectural registers r0..r7
`define LC3B_REG_COUNT 8

// first fetch address out of reset
`define LC3B_RESET_PC  16'h0000

`endif

/* hw/result_stage.sv */
`timescale 1ns/1ns

module result_stage
  import lc3b_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  ex_mem_t   ex_mem,
  input  logic      ex_mem_valid,
  output dmem_req_t dcache_req,
  input  logic      dcache_resp,
  input  lc3b_word  dcache_rdata,
  output logic      mem_stall,
  output wb_fwd_t   wb
);

  mem_wb_t mem_wb;
  logic    mem_wb_valid;

  // request held straight off ex/mem, so it is stable until resp
  always_comb begin
    dcache_req.read    = ex_mem_valid & ex_mem.ctrl.mem_read;
    dcache_req.write   = ex_mem_valid & ex_mem.ctrl.mem_write;
    dcache_req.address = ex_mem.alu_out;
    dcache_req.wdata   = ex_mem.store_data;
  end

  assign mem_stall = (dcache_req.read | dcache_req.write) & ~dcache_resp;

  // only mem/wb bubbles while the dcache is busy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb_valid <= 1'b0;
    end else begin
      mem_wb_valid <= ex_mem_valid & ~mem_stall;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb.load_regfile <= ex_mem.ctrl.load_regfile;
    mem_wb.dest         <= ex_mem.dest;
    mem_wb.value        <= ex_mem.ctrl.mem_read ? dcache_rdata : ex_mem.alu_out;
  end

  always_comb begin
    wb.valid = mem_wb_valid & mem_wb.load_regfile;
    wb.dest  = mem_wb.dest;
    wb.value = mem_wb.value;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the lc3b core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module tb_lc3b_core -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

/* src.f */
+incdir+hw
hw/lc3b_pkg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/lc3b_core.sv
tb/tb_memory_model.sv
tb/tb_lc3b_core.sv

/* tb/tb_lc3b_core.sv */
`timescale 1ns/1ns
`include "lc3b_settings.svh"

module tb_lc3b_core
  import lc3b_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      icache_read;
  lc3b_word  icache_address;
  logic      icache_resp;
  lc3b_word  icache_rdata;
  dmem_req_t dcache_req;
  logic      dcache_resp;
  lc3b_word  dcache_rdata;
  int        imem_max_delay;
  int        dmem_max_delay;
  lc3b_word  imem_image [256];
  lc3b_word  dmem_image [256];

  lc3b_word  prog [$];
  dmem_req_t exp_stores [$];   // from the reference model
  string     test_name;
  int        n_seen;
  logic      checking;
  logic      req_open;         // a request went unanswered last cycle
  dmem_req_t held_req;
  int        cycles_run;
  int        cycle_budget;

  lc3b_core uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .icache_read    (icache_read),
    .icache_address (icache_address),
    .icache_resp    (icache_resp),
    .icache_rdata   (icache_rdata),
    .dcache_req     (dcache_req),
    .dcache_resp    (dcache_resp),
    .dcache_rdata   (dcache_rdata)
  );

  tb_memory_model mem (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_max_delay (imem_max_delay),
    .dmem_max_delay (dmem_max_delay),
    .imem_image     (imem_image),
    .dmem_image     (dmem_image),
    .icache_read    (icache_read),
    .icache_address (icache_address),
    .icache_resp    (icache_resp),
    .icache_rdata   (icache_rdata),
    .dcache_req     (dcache_req),
    .dcache_resp    (dcache_resp),
    .dcache_rdata   (dcache_rdata)
  );

  always #10 clk = ~clk;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(string what, lc3b_word expected, lc3b_word actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_req(string what, dmem_req_t expected, dmem_req_t actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "request mismatch");
    end
  endtask

  // instruction encoders
  function automatic lc3b_word alu_reg(lc3b_opcode op, int dr, int sr1, int sr2);
    return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
  endfunction

  function automatic lc3b_word alu_imm(lc3b_opcode op, int dr, int sr1, int imm);
    return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
  endfunction

  function automatic lc3b_word not_word(int dr, int sr);
    return {op_not, 3'(dr), 3'(sr), 6'b111111};
  endfunction

  function automatic lc3b_word mem_word(lc3b_opcode op, int rg, int base, int off);
    return {op, 3'(rg), 3'(base), 6'(off)};
  endfunction

  // instruction-level model with no pipeline
  task automatic run_reference();
    lc3b_word  r [8];
    lc3b_word  dm [256];
    lc3b_word  ins;
    lc3b_word  a;
    lc3b_word  b;
    lc3b_word  addr;
    dmem_req_t st;
    exp_stores.delete();
    foreach (r[i]) r[i] = '0;
    dm = dmem_image;
    foreach (prog[k]) begin
      ins  = prog[k];
      a    = r[ins[8:6]];
      b    = ins[5] ? {{11{ins[4]}}, ins[4:0]} : r[ins[2:0]];
      addr = a + {{9{ins[5]}}, ins[5:0], 1'b0};
      case (lc3b_opcode'(ins[15:12]))
        op_add: r[ins[11:9]] = a + b;
        op_and: r[ins[11:9]] = a & b;
        op_not: r[ins[11:9]] = ~a;
        op_ldr: r[ins[11:9]] = dm[addr[8:1]];
        op_str: begin
          dm[addr[8:1]] = r[ins[11:9]];
          st.read    = 1'b0;
          st.write   = 1'b1;
          st.address = addr;
          st.wdata   = r[ins[11:9]];
          exp_stores.push_back(st);
        end
        default: ;
      endcase
    end
  endtask

  // store order and request stability
  always @(posedge clk) begin
    if (!checking) begin
      n_seen   = 0;
      req_open = 1'b0;
    end else begin
      if (req_open) begin
        check_req({test_name, " held request"}, held_req, dcache_req);
      end
      req_open = (dcache_req.read | dcache_req.write) & ~dcache_resp;
      held_req = dcache_req;
      if (dcache_req.write && dcache_resp) begin
        if (n_seen >= exp_stores.size()) begin
          abort_run($sformatf("%s made an extra store to %h", test_name, dcache_req.address));
        end else begin
          check_req({test_name, " store"}, exp_stores[n_seen], dcache_req);
          n_seen++;
        end
      end
    end
  end

  task automatic run_program(string name, int i_max, int d_max);
    test_name = name;
    checking  = 1'b0;
    @(posedge clk);
    rst_n          <= 1'b0;
    imem_max_delay <= i_max;
    dmem_max_delay <= d_max;
    for (int a = 0; a < 256; a++) begin
      imem_image[a] <= (a < prog.size()) ? prog[a] : '0;   // zero decodes as nop
    end
    run_reference();
    cycle_budget += prog.size() * 40 + 40;
    repeat (2) @(posedge clk);
    rst_n    <= 1'b1;
    checking = 1'b1;
    while (n_seen < exp_stores.size()) @(posedge clk);
    repeat (30) @(posedge clk);   // drain so a duplicated store shows up
  endtask

  task automatic reset_state();
    test_name = "reset";
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_word("reset dcache flags", '0, lc3b_word'({dcache_req.read, dcache_req.write}));
    @(posedge clk);
    if (!icache_read) begin
      abort_run("icache_read did not rise in the first cycle after reset");
    end
    check_word("reset first fetch", `LC3B_RESET_PC, icache_address);
    check_word("reset dcache flags", '0, lc3b_word'({dcache_req.read, dcache_req.write}));
  endtask

  task automatic build_alu_chain();
    prog.delete();
    prog.push_back(alu_imm(op_add, 1, 0, 5));
    prog.push_back(alu_imm(op_add, 2, 1, -3));   // back to back on r1
    prog.push_back(alu_reg(op_add, 3, 1, 2));
    prog.push_back(alu_imm(op_and, 4, 3, 6));
    prog.push_back(not_word(5, 4));
    prog.push_back(alu_reg(op_and, 6, 5, 3));
    prog.push_back(alu_imm(op_add, 7, 0, 8));    // store base
    prog.push_back(mem_word(op_str, 6, 7, 0));
    prog.push_back(mem_word(op_str, 3, 7, 1));
    prog.push_back(mem_word(op_str, 5, 7, 2));
    prog.push_back(alu_reg(op_add, 1, 1, 1));
    prog.push_back(alu_reg(op_add, 1, 1, 1));
    prog.push_back(mem_word(op_str, 1, 7, -1));  // data straight from the add
    prog.push_back(not_word(4, 4));
    prog.push_back(mem_word(op_str, 4, 7, 3));
  endtask

  task automatic alu_chain();
    build_alu_chain();
    run_program("alu_chain", 0, 0);
  endtask

  task automatic load_then_use();
    prog.delete();
    prog.push_back(alu_imm(op_add, 7, 0, 15));
    prog.push_back(alu_imm(op_add, 7, 7, 15));
    prog.push_back(alu_imm(op_add, 7, 7, 2));    // base 32
    prog.push_back(mem_word(op_ldr, 1, 7, 2));
    prog.push_back(alu_imm(op_add, 2, 1, 7));    // uses the load at once
    prog.push_back(mem_word(op_str, 2, 7, 4));
    prog.push_back(mem_word(op_ldr, 3, 7, -1));
    prog.push_back(mem_word(op_str, 3, 7, 5));   // loaded word as store data
    prog.push_back(mem_word(op_ldr, 4, 7, 0));
    prog.push_back(alu_reg(op_add, 5, 4, 1));
    prog.push_back(mem_word(op_str, 5, 7, 6));
    run_program("load_use", 0, 0);
  endtask

  task automatic dcache_delayed_chain();
    build_alu_chain();
    run_program("alu_chain_dcache_delay", 0, 5);
  endtask

  task automatic icache_delayed_mix();
    prog.delete();
    prog.push_back(alu_imm(op_add, 7, 0, 12));
    prog.push_back(mem_word(op_ldr, 1, 7, 0));
    prog.push_back(mem_word(op_ldr, 2, 7, 1));
    prog.push_back(alu_reg(op_add, 3, 1, 2));
    prog.push_back(mem_word(op_str, 3, 7, 8));
    prog.push_back(not_word(4, 3));
    prog.push_back(alu_imm(op_and, 5, 4, 15));
    prog.push_back(mem_word(op_str, 5, 7, 9));
    prog.push_back(mem_word(op_ldr, 6, 7, 8));   // reads back the first store
    prog.push_back(alu_imm(op_add, 6, 6, -1));
    prog.push_back(mem_word(op_str, 6, 7, 10));
    prog.push_back(mem_word(op_str, 1, 7, 11));
    run_program("mixed_icache_delay", 5, 0);
  endtask

  // watchdog budget grows as each program is loaded
  initial begin
    cycles_run = 0;
    forever begin
      @(posedge clk);
      cycles_run++;
      if (cycles_run > cycle_budget) begin
        abort_run($sformatf("run hung in %s after %0d cycles", test_name, cycles_run));
      end
    end
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    imem_max_delay = 0;
    dmem_max_delay = 0;
    checking       = 1'b0;
    cycle_budget   = 40;
    test_name      = "startup";
    void'($urandom(32'h22c15a62));
    for (int a = 0; a < 256; a++) begin
      imem_image[a] = '0;
      dmem_image[a] = {8'(a) ^ 8'ha5, 8'(a)};   // index xor a5 above the index
    end
    reset_state();
    alu_chain();
    load_then_use();
    dcache_delayed_chain();
    icache_delayed_mix();
    $display("** PASS **");
    $finish;
  end

endmodule

/* tb/tb_memory_model.sv */
`timescale 1ns/1ns

module tb_memory_model
  import lc3b_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  int        imem_max_delay,
  input  int        dmem_max_delay,
  input  lc3b_word  imem_image [256],
  input  lc3b_word  dmem_image [256],
  input  logic      icache_read,
  input  lc3b_word  icache_address,
  output logic      icache_resp,
  output lc3b_word  icache_rdata,
  input  dmem_req_t dcache_req,
  output logic      dcache_resp,
  output lc3b_word  dcache_rdata
);

  lc3b_word dmem [256];   // working copy reloaded from the image in reset
  int       i_wait;
  int       i_delay;
  int       d_wait;
  int       d_delay;

  function automatic int draw_delay(int max_delay);
    if (max_delay <= 0) begin
      return 0;
    end
    return int'($urandom % (max_delay + 1));
  endfunction

  // zero delay answers in the request cycle
  assign icache_resp  = icache_read & (i_wait >= i_delay);
  assign icache_rdata = imem_image[icache_address[8:1]];
  assign dcache_resp  = (dcache_req.read | dcache_req.write) & (d_wait >= d_delay);
  assign dcache_rdata = dmem[dcache_req.address[8:1]];

  always @(posedge clk) begin
    if (!rst_n) begin
      i_wait  <= 0;
      i_delay <= draw_delay(imem_max_delay);
    end else if (icache_resp) begin
      i_wait  <= 0;           // next fetch draws a fresh delay
      i_delay <= draw_delay(imem_max_delay);
    end else if (icache_read) begin
      i_wait <= i_wait + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      d_wait  <= 0;
      d_delay <= draw_delay(dmem_max_delay);
      dmem    <= dmem_image;
    end else if (dcache_resp) begin
      d_wait  <= 0;
      d_delay <= draw_delay(dmem_max_delay);
      if (dcache_req.write) begin
        dmem[dcache_req.address[8:1]] <= dcache_req.wdata;
      end
    end else if (dcache_req.read || dcache_req.write) begin
      d_wait <= d_wait + 1;
    end
  end

endmodule
